// File: proc.f
+incdir+source
source/isaPkg.sv
source/ctrlPkg.sv
source/ctrlIf.sv
source/control.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/memory.sv
source/proc.sv
tb/proc_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the proc testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module proc_tb -f proc.f -o procSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/procSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# Pass only when the testbench printed its pass line
if grep -q "^TEST RESULT: PASS$" sim.log; then
   exit 0
fi
echo "Pass line missing from sim.log"
exit 1

// File: source/control.sv
module control (
   input isaPkg::word_t instr,
   ctrlIf.ctrl          c
);
   import isaPkg::*;
   import ctrlPkg::*;

   opcode_t op;

   // Opcode field
   assign op = opcode_t'(instr[15:12]);

   always_comb
   begin
      // Inert defaults, nothing written
      c.regWrite = 1'b0;
      c.aluOp    = ALU_ADD;
      c.useImm   = 1'b0;
      c.immKind  = 1'b0;
      c.memRead  = 1'b0;
      c.memWrite = 1'b0;
      c.wbSel    = WB_ALU;
      c.branch   = BR_NONE;
      c.halt     = 1'b0;
      c.illegal  = 1'b0;
      case (op)
         // R-type group
         OP_ADD:
         begin
            c.regWrite = 1'b1;
         end
         OP_SUB:
         begin
            c.regWrite = 1'b1;
            c.aluOp    = ALU_SUB;
         end
         OP_AND:
         begin
            c.regWrite = 1'b1;
            c.aluOp    = ALU_AND;
         end
         OP_XOR:
         begin
            c.regWrite = 1'b1;
            c.aluOp    = ALU_XOR;
         end
         OP_SLL:
         begin
            c.regWrite = 1'b1;
            c.aluOp    = ALU_SLL;
         end
         // rs + imm6
         OP_ADDI:
         begin
            c.regWrite = 1'b1;
            c.useImm   = 1'b1;
         end
         // Address rs + imm6, load data back to rd
         OP_LD:
         begin
            c.regWrite = 1'b1;
            c.useImm   = 1'b1;
            c.memRead  = 1'b1;
            c.wbSel    = WB_MEM;
         end
         OP_ST:
         begin
            c.useImm   = 1'b1;
            c.memWrite = 1'b1;
         end
         // imm9 straight through the ALU
         OP_LBI:
         begin
            c.regWrite = 1'b1;
            c.useImm   = 1'b1;
            c.immKind  = 1'b1;
            c.aluOp    = ALU_PASSB;
         end
         OP_BEQZ:
         begin
            c.immKind = 1'b1;
            c.branch  = BR_EQZ;
         end
         OP_BNEZ:
         begin
            c.immKind = 1'b1;
            c.branch  = BR_NEZ;
         end
         OP_J:
         begin
            c.branch = BR_JUMP;
         end
         // Link value is pcInc
         OP_JAL:
         begin
            c.regWrite = 1'b1;
            c.wbSel    = WB_LINK;
            c.branch   = BR_JUMP;
         end
         OP_JR:
         begin
            c.branch = BR_REG;
         end
         OP_HALT:
         begin
            c.halt = 1'b1;
         end
         // OP_ILL, halts with error
         default:
         begin
            c.halt    = 1'b1;
            c.illegal = 1'b1;
         end
      endcase
   end

endmodule

// File: source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath word, also the address width
`define WORD_WIDTH 16

// General purpose registers r0..r7
`define REG_COUNT 8

// Instruction memory depth in words
`define IMEM_DEPTH 256

// Data memory depth in words
`define DMEM_DEPTH 256

`endif

// File: source/ctrlIf.sv
interface ctrlIf;
   import ctrlPkg::*;

   logic    regWrite;
   aluOp_t  aluOp;
   // Operand B from the immediate instead of rt
   logic    useImm;
   // Low picks imm6, high picks imm9
   logic    immKind;
   logic    memRead;
   logic    memWrite;
   wbSel_t  wbSel;
   branch_t branch;
   logic    halt;
   logic    illegal;

   modport ctrl (
      output regWrite, aluOp, useImm, immKind, memRead, memWrite, wbSel, branch,
      output halt, illegal
   );
   modport dec (input regWrite, useImm, immKind);
   // Execute also needs useImm for the operand B mux
   modport ex  (input aluOp, branch, useImm);
   modport mem (input memRead, memWrite, wbSel);
   modport fet (input halt, illegal);

endinterface

// File: source/ctrlPkg.sv
package ctrlPkg;

   // ALU function
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_SLL,
      ALU_PASSB
   } aluOp_t;

   // Source of the register write value
   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_LINK
   } wbSel_t;

   // Next-PC behaviour
   typedef enum logic [2:0] {
      BR_NONE,
      BR_EQZ,
      BR_NEZ,
      BR_JUMP,
      BR_REG
   } branch_t;

endpackage

// File: source/decode.sv
`include "cpu_config.svh"

module decode (
   input  logic          clk,
   input  logic          rst,
   ctrlIf.dec            c,
   input  isaPkg::word_t instr,
   input  isaPkg::word_t writeData,
   output isaPkg::word_t rdData,
   output isaPkg::word_t rsData,
   output isaPkg::word_t rtData,
   output isaPkg::word_t immVal
);
   import isaPkg::*;

   opcode_t  op;
   regAddr_t rdAddr;
   regAddr_t rsAddr;
   regAddr_t rtAddr;
   regAddr_t destAddr;
   imm6_t    imm6;
   imm9_t    imm9;
   imm12_t   imm12;
   word_t    regs [`REG_COUNT];

   // Instruction fields
   assign op     = opcode_t'(instr[15:12]);
   assign rdAddr = instr[11:9];
   assign rsAddr = instr[8:6];
   assign rtAddr = instr[5:3];
   assign imm6   = instr[IMM6_W-1:0];
   assign imm9   = instr[IMM9_W-1:0];
   assign imm12  = instr[IMM12_W-1:0];

   // JAL links into r7
   assign destAddr = (op == OP_JAL) ? LINK_REG : rdAddr;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < `REG_COUNT; i++)
            regs[i] <= '0;
      end
      else if (c.regWrite)
         regs[destAddr] <= writeData;
   end

   // Asynchronous reads
   assign rdData = regs[rdAddr];
   assign rsData = regs[rsAddr];
   assign rtData = regs[rtAddr];

   // Sign extension with imm12 for J and JAL only
   always_comb
   begin
      if (op == OP_J || op == OP_JAL)
         immVal = {{(`WORD_WIDTH-IMM12_W){imm12[IMM12_W-1]}}, imm12};
      else if (c.immKind)
         immVal = {{(`WORD_WIDTH-IMM9_W){imm9[IMM9_W-1]}}, imm9};
      else
         immVal = {{(`WORD_WIDTH-IMM6_W){imm6[IMM6_W-1]}}, imm6};
   end

endmodule

// File: source/execute.sv
module execute (
   ctrlIf.ex             c,
   input  isaPkg::word_t rdData,
   input  isaPkg::word_t rsData,
   input  isaPkg::word_t rtData,
   input  isaPkg::word_t immVal,
   input  isaPkg::word_t pcInc,
   output isaPkg::word_t aluOut,
   output isaPkg::word_t nextPc
);
   import isaPkg::*;
   import ctrlPkg::*;

   word_t opB;
   word_t relTarget;
   logic  rdZero;

   // Operand B, rt for R-type else immediate
   assign opB = c.useImm ? immVal : rtData;

   // ALU, all results wrap at 16 bits
   always_comb
   begin
      case (c.aluOp)
         ALU_ADD:
            aluOut = rsData + opB;
         ALU_SUB:
            aluOut = rsData - opB;
         ALU_AND:
            aluOut = rsData & opB;
         ALU_XOR:
            aluOut = rsData ^ opB;
         // Shift amount from low 4 bits
         ALU_SLL:
            aluOut = rsData << opB[3:0];
         // LBI value
         ALU_PASSB:
            aluOut = opB;
         default:
            aluOut = '0;
      endcase
   end

   // Branch and jump offsets are relative to pc+1
   assign relTarget = pcInc + immVal;
   assign rdZero    = (rdData == '0);

   // Next PC
   always_comb
   begin
      case (c.branch)
         BR_EQZ:
            nextPc = rdZero ? relTarget : pcInc;
         BR_NEZ:
            nextPc = rdZero ? pcInc : relTarget;
         BR_JUMP:
            nextPc = relTarget;
         // JR target held in rd
         BR_REG:
            nextPc = rdData;
         default:
            nextPc = pcInc;
      endcase
   end

endmodule

// File: source/fetch.sv
`include "cpu_config.svh"

module fetch (
   input  logic          clk,
   input  logic          rst,
   ctrlIf.fet            c,
   input  isaPkg::word_t nextPc,
   input  logic          imemWrEn,
   input  isaPkg::word_t imemAddr,
   input  isaPkg::word_t imemData,
   output isaPkg::word_t instr,
   output isaPkg::word_t pcInc,
   output logic          halted,
   output logic          err
);
   import isaPkg::*;

   localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

   word_t pc;
   word_t imem [`IMEM_DEPTH];

   // Program load port, open only during reset
   always_ff @(posedge clk)
   begin
      if (rst && imemWrEn)
         imem[imemAddr[IMEM_AW-1:0]] <= imemData;
   end

   // PC freezes on the halting edge
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc     <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end
      else
      begin
         if (!c.halt)
            pc <= nextPc;
         halted <= halted | c.halt;
         err    <= err | c.illegal;
      end
   end

   // Once halted, feed HALT so later cycles do nothing
   assign instr = halted ? word_t'({OP_HALT, {(`WORD_WIDTH-4){1'b0}}})
                         : imem[pc[IMEM_AW-1:0]];
   assign pcInc = pc + word_t'(1);

endmodule

// File: source/isaPkg.sv
`include "cpu_config.svh"

package isaPkg;

   // Data word or word address
   typedef logic [`WORD_WIDTH-1:0] word_t;

   // Register index
   localparam int REG_AW = $clog2(`REG_COUNT);
   typedef logic [REG_AW-1:0] regAddr_t;

   // Opcode in bits 15..12
   typedef enum logic [3:0] {
      OP_HALT = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLL  = 4'd5,
      OP_ADDI = 4'd6,
      OP_LD   = 4'd7,
      OP_ST   = 4'd8,
      OP_LBI  = 4'd9,
      OP_BEQZ = 4'd10,
      OP_BNEZ = 4'd11,
      OP_J    = 4'd12,
      OP_JAL  = 4'd13,
      OP_JR   = 4'd14,
      OP_ILL  = 4'd15
   } opcode_t;

   // Immediate field widths, all sign-extended
   localparam int IMM6_W  = 6;
   localparam int IMM9_W  = 9;
   localparam int IMM12_W = 12;
   typedef logic [IMM6_W-1:0]  imm6_t;
   typedef logic [IMM9_W-1:0]  imm9_t;
   typedef logic [IMM12_W-1:0] imm12_t;

   // JAL link register
   localparam regAddr_t LINK_REG = regAddr_t'(`REG_COUNT - 1);

   // Stores here go to the output port
   localparam word_t OUT_PORT_ADDR = 16'hFFFF;

endpackage

// File: source/memory.sv
`include "cpu_config.svh"

module memory (
   input  logic          clk,
   input  logic          rst,
   ctrlIf.mem            c,
   input  isaPkg::word_t aluOut,
   input  isaPkg::word_t rdData,
   input  isaPkg::word_t pcInc,
   output isaPkg::word_t writeData,
   output logic          outValid,
   output isaPkg::word_t outData
);
   import isaPkg::*;
   import ctrlPkg::*;

   localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

   word_t dmem [`DMEM_DEPTH];
   word_t loadData;
   logic  toPort;

   // Word addressed by the low bits
   assign toPort   = (aluOut == OUT_PORT_ADDR);
   assign loadData = c.memRead ? dmem[aluOut[DMEM_AW-1:0]] : '0;

   // Port stores bypass the array
   always_ff @(posedge clk)
   begin
      if (!rst && c.memWrite && !toPort)
         dmem[aluOut[DMEM_AW-1:0]] <= rdData;
   end

   // One-cycle strobe per port store
   always_ff @(posedge clk)
   begin
      if (rst)
         outValid <= 1'b0;
      else
         outValid <= c.memWrite && toPort;
   end

   // Last word stored to the port
   always_ff @(posedge clk)
   begin
      if (c.memWrite && toPort)
         outData <= rdData;
   end

   // Write-back select
   always_comb
   begin
      case (c.wbSel)
         WB_MEM:
            writeData = loadData;
         WB_LINK:
            writeData = pcInc;
         default:
            writeData = aluOut;
      endcase
   end

endmodule

// File: source/proc.sv
module proc (
   input  logic          clk,
   input  logic          rst,
   input  logic          imemWrEn,
   input  isaPkg::word_t imemAddr,
   input  isaPkg::word_t imemData,
   output logic          outValid,
   output isaPkg::word_t outData,
   output logic          halted,
   output logic          err
);
   import isaPkg::*;

   word_t instr;
   word_t pcInc;
   word_t nextPc;
   word_t rdData;
   word_t rsData;
   word_t rtData;
   word_t immVal;
   word_t aluOut;
   word_t writeData;

   // Decoded control, shared by all stages
   ctrlIf ctrlBus ();

   control controlUnit (
      .instr (instr),
      .c     (ctrlBus.ctrl)
   );

   // PC, program memory, halt and error flags
   fetch fetchStage (
      .clk      (clk),
      .rst      (rst),
      .c        (ctrlBus.fet),
      .nextPc   (nextPc),
      .imemWrEn (imemWrEn),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .instr    (instr),
      .pcInc    (pcInc),
      .halted   (halted),
      .err      (err)
   );

   // Register file and immediates
   decode decodeStage (
      .clk       (clk),
      .rst       (rst),
      .c         (ctrlBus.dec),
      .instr     (instr),
      .writeData (writeData),
      .rdData    (rdData),
      .rsData    (rsData),
      .rtData    (rtData),
      .immVal    (immVal)
   );

   // ALU and next PC
   execute executeStage (
      .c      (ctrlBus.ex),
      .rdData (rdData),
      .rsData (rsData),
      .rtData (rtData),
      .immVal (immVal),
      .pcInc  (pcInc),
      .aluOut (aluOut),
      .nextPc (nextPc)
   );

   // Data memory, output port, write-back mux
   memory memoryStage (
      .clk       (clk),
      .rst       (rst),
      .c         (ctrlBus.mem),
      .aluOut    (aluOut),
      .rdData    (rdData),
      .pcInc     (pcInc),
      .writeData (writeData),
      .outValid  (outValid),
      .outData   (outData)
   );

endmodule

// File: tb/proc_tb.sv
module proc_tb;
   import isaPkg::*;

   // Cycle budget for each wait on halted
   localparam int HALT_LIMIT   = 500;
   // Observation window after a halt
   localparam int QUIET_CYCLES = 20;
   localparam int ARITH_ROUNDS = 3;

   logic  clk;
   logic  rst;
   logic  imemWrEn;
   word_t imemAddr;
   word_t imemData;
   logic  outValid;
   word_t outData;
   logic  halted;
   logic  err;

   // Program image, expected port words
   word_t       progQ[$];
   word_t       expQ[$];
   word_t       expHead   = '0;
   int          expLeft   = 0;
   logic        rstHeld   = 1'b0;
   logic [31:0] lfsrState = 32'h2e82;
   int          errors    = 0;
   logic        timedOut  = 1'b0;

   proc u_proc (
      .clk      (clk),
      .rst      (rst),
      .imemWrEn (imemWrEn),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .outValid (outValid),
      .outData  (outData),
      .halted   (halted),
      .err      (err)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;
   end

   // One expected word used up per port strobe
   always @(posedge clk)
   begin
      rstHeld <= rst;
      if (!rst && outValid && expQ.size() > 0)
         void'(expQ.pop_front());
   end

   // Queue head copied mid-cycle, stable at the next rising edge
   always @(negedge clk)
   begin
      expLeft <= expQ.size();
      expHead <= (expQ.size() > 0) ? expQ[0] : '0;
   end

   portWordCheck: assert property (@(posedge clk) disable iff (rst)
      outValid |-> (expLeft > 0 && outData == expHead))
   else
   begin
      errors++;
      $display("Error at %0t: port word %h, expected %h with %0d pending", $time,
               $sampled(outData), $sampled(expHead), $sampled(expLeft));
   end

   // From the second reset cycle on
   resetQuietCheck: assert property (@(posedge clk)
      (rst && rstHeld) |-> (!outValid && !halted && !err))
   else
   begin
      errors++;
      $display("Error at %0t: outValid, halted or err high during reset", $time);
   end

   haltQuietCheck: assert property (@(posedge clk) disable iff (rst)
      halted |-> !outValid)
   else
   begin
      errors++;
      $display("Error at %0t: port store after halt", $time);
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // One LFSR step per bit
   function automatic word_t randomBits(input int n);
      word_t r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsrState = lfsrNext(lfsrState);
         r = {r[14:0], lfsrState[0]};
      end
      return r;
   endfunction

   function automatic word_t signExtend(input word_t v, input int width);
      word_t shifted;
      shifted = v << (16 - width);
      return $signed(shifted) >>> (16 - width);
   endfunction

   // Instruction formats
   function automatic word_t encodeR(input opcode_t op, input int rd, input int rs, input int rt);
      return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
   endfunction

   function automatic word_t encodeI(input opcode_t op, input int rd, input int rs, input int imm);
      return {op, 3'(rd), 3'(rs), 6'(imm)};
   endfunction

   function automatic word_t encodeB(input opcode_t op, input int rd, input int imm);
      return {op, 3'(rd), 9'(imm)};
   endfunction

   function automatic word_t encodeJ(input opcode_t op, input int imm);
      return {op, 12'(imm)};
   endfunction

   task automatic emit(input word_t w);
      progQ.push_back(w);
   endtask

   // ST r, r0, -1 hits 16'hFFFF
   task automatic storeToPort(input int r);
      emit(encodeI(OP_ST, r, 0, -1));
   endtask

   task automatic emitMarker(input int value);
      emit(encodeB(OP_LBI, 5, value));
      storeToPort(5);
   endtask

   // Result lands in r3, then goes out the port
   task automatic emitCheckedOp(input word_t instr, input word_t expected);
      emit(instr);
      storeToPort(3);
      expQ.push_back(expected);
   endtask

   task automatic buildArithmetic(input int rounds);
      word_t a;
      word_t b;
      word_t imm6;
      for (int n = 0; n < rounds; n++)
      begin
         a    = randomBits(9);
         b    = randomBits(9);
         imm6 = randomBits(6);
         emit(encodeB(OP_LBI, 1, a));
         emit(encodeB(OP_LBI, 2, b));
         a = signExtend(a, 9);
         b = signExtend(b, 9);
         emitCheckedOp(encodeR(OP_ADD, 3, 1, 2), a + b);
         emitCheckedOp(encodeR(OP_SUB, 3, 1, 2), a - b);
         emitCheckedOp(encodeR(OP_AND, 3, 1, 2), a & b);
         emitCheckedOp(encodeR(OP_XOR, 3, 1, 2), a ^ b);
         // Shift by rt[3:0] only
         emitCheckedOp(encodeR(OP_SLL, 3, 1, 2), a << b[3:0]);
         emitCheckedOp(encodeI(OP_ADDI, 3, 1, imm6), a + signExtend(imm6, 6));
      end
   endtask

   // Round trip through data word 5
   task automatic buildMemory;
      word_t c;
      c = randomBits(9);
      emit(encodeB(OP_LBI, 1, c));
      emit(encodeI(OP_ST, 1, 0, 5));
      emit(encodeI(OP_LD, 4, 0, 5));
      storeToPort(4);
      expQ.push_back(signExtend(c, 9));
   endtask

   // Offset 2 skips one marker, 8'hAx markers must never show
   task automatic buildBranches;
      emit(encodeB(OP_LBI, 6, 0));
      emit(encodeB(OP_BEQZ, 6, 2));
      emitMarker('hA1);
      emitMarker('h11);
      emit(encodeB(OP_BNEZ, 6, 2));
      emitMarker('h12);
      emit(encodeB(OP_LBI, 6, 3));
      emit(encodeB(OP_BNEZ, 6, 2));
      emitMarker('hA2);
      emitMarker('h13);
      emit(encodeB(OP_BEQZ, 6, 2));
      emitMarker('h14);
      expQ.push_back(16'h0011);
      expQ.push_back(16'h0012);
      expQ.push_back(16'h0013);
      expQ.push_back(16'h0014);
   endtask

   task automatic buildJumps;
      int jalPc;
      emit(encodeJ(OP_J, 2));
      emitMarker('hA3);
      emitMarker('h15);
      expQ.push_back(16'h0015);
      // Subroutine sits between the return point and HALT
      jalPc = progQ.size();
      emit(encodeJ(OP_JAL, 2));
      storeToPort(7);
      emit(encodeJ(OP_J, 3));
      emitMarker('h16);
      emit(encodeB(OP_JR, 7, 0));
      emit(encodeJ(OP_HALT, 0));
      emitMarker('hA4);
      expQ.push_back(16'h0016);
      expQ.push_back(word_t'(jalPc + 1));
   endtask

   // One port word, then the illegal opcode
   task automatic buildIllegal;
      word_t d;
      d = randomBits(9);
      emit(encodeB(OP_LBI, 1, d));
      storeToPort(1);
      expQ.push_back(signExtend(d, 9));
      emit(encodeJ(OP_ILL, 0));
      storeToPort(1);
      emit(encodeJ(OP_HALT, 0));
   endtask

   // Load under reset, then five more reset cycles
   task automatic loadAndRun;
      @(negedge clk);
      rst = 1'b1;
      for (int i = 0; i < progQ.size(); i++)
      begin
         @(negedge clk);
         imemWrEn = 1'b1;
         imemAddr = word_t'(i);
         imemData = progQ[i];
      end
      @(negedge clk);
      imemWrEn = 1'b0;
      repeat (5)
         @(negedge clk);
      rst = 1'b0;
   endtask

   task automatic waitHalted;
      int cycles;
      cycles = 0;
      while (!halted && cycles < HALT_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!halted)
      begin
         timedOut = 1'b1;
         $display("Timeout: halted did not rise within %0d cycles", HALT_LIMIT);
      end
   endtask

   task automatic checkHaltState(input logic expectErr);
      assert (err == expectErr)
      else
      begin
         errors++;
         $display("Error at %0t: err is %b, expected %b", $time, err, expectErr);
      end
      assert (expQ.size() == 0)
      else
      begin
         errors++;
         $display("Error at %0t: %0d port words never appeared", $time, expQ.size());
      end
   endtask

   initial
   begin
      rst      = 1'b1;
      imemWrEn = 1'b0;
      imemAddr = '0;
      imemData = '0;
      buildArithmetic(ARITH_ROUNDS);
      buildMemory();
      buildBranches();
      buildJumps();
      loadAndRun();
      waitHalted();
      if (!timedOut)
      begin
         repeat (QUIET_CYCLES)
            @(negedge clk);
         checkHaltState(1'b0);
         progQ.delete();
         buildIllegal();
         loadAndRun();
         waitHalted();
      end
      if (!timedOut)
      begin
         repeat (QUIET_CYCLES)
            @(negedge clk);
         checkHaltState(1'b1);
      end
      $display("Run complete: %0d errors, %0d timeouts", errors, timedOut);
      if (errors == 0 && !timedOut)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule
